// ==== tb.f ====
hw/decodePkg.sv
hw/regFile.sv
hw/scoreboard.sv
hw/instDecoder.sv
hw/branchResolve.sv
hw/decodeStage.sv
verif/decodeTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench, then search the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module decodeTb -o decodeSim \
  && ./obj_dir/decodeSim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1
grep -q "All tests passed!" sim.log || exit 1
exit 0

// ==== verif/decodeTb.sv ====
`timescale 1ns/1ps

module decodeTb;
  import decodePkg::*;

  localparam int clockPeriod = 4;
  // rough cycle count of all tests, plus slack for the watchdog
  localparam int testCycles = 110;
  localparam int marginCycles = 200;
  localparam logic [Xlen-1:0] pcBase = 64'h0000_0000_8000_0000;

  logic            clock;
  logic            reset;
  logic            ifValid;
  logic [31:0]     ifInst;
  logic [Xlen-1:0] ifPc;
  logic [Xlen-1:0] nextPc;
  logic            exReady;
  logic            wbEn;
  regAddrT         wbAddr;
  logic [Xlen-1:0] wbData;
  logic [Xlen-1:0] mtvec;
  logic [Xlen-1:0] mepc;
  logic            exValid;
  logic [Xlen-1:0] exPc;
  aluOpE           exOp;
  logic [Xlen-1:0] exRd1;
  logic [Xlen-1:0] exRd2;
  logic [Xlen-1:0] exRs2;
  logic [Xlen-1:0] exImm;
  regAddrT         exWaddr;
  logic            exWen;
  logic            exLoad;
  logic            exStore;
  logic [7:0]      exWmask;
  logic            exWordOp;
  logic            exCsr;
  logic            exEcall;
  logic            exMret;
  logic            exBreak;
  logic            exAbort;
  logic [2:0]      exFunc3;
  logic            ifReady;
  npcKindE         npcKind;
  logic [Xlen-1:0] npcTarget;
  logic            npcValid;

  int              seed = 32'h71fd_b739;
  int              checks = 0;
  int              errors = 0;
  // what the register file should hold, kept from the wb writes
  logic [Xlen-1:0] regVal [32];

  decodeStage dut0 (.*);

  always #(clockPeriod / 2) clock = ~clock;

  initial begin
    #((testCycles + marginCycles) * clockPeriod);
    $display("watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

  // instruction builders
  function automatic logic [31:0] rInst(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] iInst(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] sInst(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
  endfunction

  function automatic logic [31:0] bInst(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
  endfunction

  function automatic logic [31:0] uInst(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] jInst(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
  endfunction

  // reference rules
  function automatic logic [Xlen-1:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [Xlen-1:0] sext13(input logic [12:0] v);
    return {{51{v[12]}}, v};
  endfunction

  function automatic logic [Xlen-1:0] sext21(input logic [20:0] v);
    return {{43{v[20]}}, v};
  endfunction

  function automatic logic [Xlen-1:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic branchCond(input logic [2:0] f3, input logic [Xlen-1:0] a,
                                      input logic [Xlen-1:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // one byte enable per byte of the access width
  function automatic logic [7:0] storeMask(input logic [1:0] f3);
    logic [15:0] bits;
    bits = (16'h1 << (4'h1 << f3)) - 16'h1;
    return bits[7:0];
  endfunction

  function automatic logic [Xlen-1:0] randWord();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic checkEq(input string name, input logic [Xlen-1:0] got,
                         input logic [Xlen-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic tick();
    @(posedge clock);
    #1;
  endtask

  // leaves the strobe up for one edge
  task automatic writeReg(input logic [4:0] addr, input logic [Xlen-1:0] data);
    tick();
    ifValid = 1'b0;
    wbEn = 1'b1;
    wbAddr = addr;
    wbData = data;
    if (addr != 5'd0) begin
      regVal[addr] = data;
    end
  endtask

  // returns at the sampling point, mid-cycle
  task automatic applyInst(input logic [31:0] inst, input logic [Xlen-1:0] pc,
                           input logic valid, input logic ready);
    tick();
    wbEn = 1'b0;
    ifInst = inst;
    ifPc = pc;
    nextPc = pc + 64'd4;
    ifValid = valid;
    exReady = ready;
    #1;
  endtask

  task automatic aluCase(input logic [31:0] inst, input aluOpE op, input logic [Xlen-1:0] rd1,
                         input logic [Xlen-1:0] rd2, input logic [Xlen-1:0] imm);
    applyInst(inst, pcBase + 64'h40, 1'b1, 1'b0);
    checkEq("exOp", 64'(exOp), 64'(op));
    checkEq("exRd1", exRd1, rd1);
    checkEq("exRd2", exRd2, rd2);
    checkEq("exImm", exImm, imm);
    checkEq("exPc", exPc, pcBase + 64'h40);
    checkEq("exWaddr", 64'(exWaddr), 64'(inst[11:7]));
    checkEq("exFunc3", 64'(exFunc3), 64'(inst[14:12]));
    checkEq("exRs2", exRs2, regVal[inst[24:20]]);
    checkBit("exWordOp", exWordOp, inst[6:0] == opRw || inst[6:0] == opImmW);
  endtask

  task automatic branchCase(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                            input logic [12:0] off);
    logic            taken;
    logic [Xlen-1:0] pc;
    pc = pcBase + 64'h100;
    taken = branchCond(f3, regVal[rs1], regVal[rs2]);
    applyInst(bInst(off, rs2, rs1, f3), pc, 1'b1, 1'b0);
    checkEq("npcKind", 64'(npcKind), taken ? 64'(npcBranch) : 64'(npcSeq));
    checkEq("npcTarget", npcTarget, taken ? pc + sext13(off) : pc + 64'd4);
    checkBit("npcValid", npcValid, 1'b1);
  endtask

  task automatic checkFlags(input logic load, input logic store, input logic [7:0] mask,
                            input logic wen, input logic csr, input logic brk,
                            input logic abort);
    checkBit("exLoad", exLoad, load);
    checkBit("exStore", exStore, store);
    checkEq("exWmask", 64'(exWmask), 64'(mask));
    checkBit("exWen", exWen, wen);
    checkBit("exCsr", exCsr, csr);
    checkBit("exBreak", exBreak, brk);
    checkBit("exAbort", exAbort, abort);
  endtask

  task automatic resetTest();
    for (int r = 0; r < 32; r++) begin
      applyInst(rInst(7'h00, 5'(r), 5'(r), 3'b000, 5'd0, opR), pcBase, 1'b0, 1'b0);
      checkEq("exRd1", exRd1, 64'd0);
      checkEq("exRs2", exRs2, 64'd0);
      checkBit("exValid", exValid, 1'b0);
      checkBit("npcValid", npcValid, 1'b0);
    end
  endtask

  task automatic aluTest();
    logic [Xlen-1:0] a;
    logic [Xlen-1:0] b;
    logic [Xlen-1:0] pc;
    pc = pcBase + 64'h40;
    writeReg(5'd1, randWord());
    writeReg(5'd2, randWord());
    a = regVal[1];
    b = regVal[2];
    aluCase(rInst(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, opR), aluAdd, a, b, 64'd0);
    aluCase(rInst(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, opR), aluSub, a, b, 64'd0);
    aluCase(iInst(12'hf9c, 5'd1, 3'b000, 5'd3, opImm), aluAdd, a, sext12(12'hf9c),
            sext12(12'hf9c));
    aluCase(iInst(12'h40d, 5'd1, 3'b101, 5'd3, opImm), aluSra, a, 64'd13, sext12(12'h40d));
    aluCase(iInst(12'h407, 5'd1, 3'b101, 5'd3, opImmW), aluSra, sext32(a[31:0]), 64'd7,
            sext12(12'h407));
    aluCase(rInst(7'h00, 5'd2, 5'd1, 3'b101, 5'd3, opRw), aluSrl, {32'd0, a[31:0]},
            64'(b[4:0]), 64'd0);
    aluCase(rInst(7'h01, 5'd2, 5'd1, 3'b100, 5'd3, opRw), aluDivs, sext32(a[31:0]),
            sext32(b[31:0]), 64'd0);
    aluCase(uInst(20'h80001, 5'd3, opLui), aluAdd, 64'd0, sext32(32'h8000_1000),
            sext32(32'h8000_1000));
    aluCase(uInst(20'h12345, 5'd3, opAuipc), aluAdd, pc, 64'h1234_5000, 64'h1234_5000);
  endtask

  task automatic branchTest();
    logic [Xlen-1:0] pc;
    pc = pcBase + 64'h200;
    writeReg(5'd10, 64'hffff_ffff_ffff_fffd);
    writeReg(5'd11, 64'd7);
    writeReg(5'd12, 64'd7);
    // even base so that base plus 7 has bit 0 set
    writeReg(5'd13, randWord() & ~64'd1);
    branchCase(3'b000, 5'd11, 5'd12, 13'h1ff0);
    branchCase(3'b000, 5'd10, 5'd11, 13'd24);
    branchCase(3'b001, 5'd10, 5'd11, 13'h1ff0);
    branchCase(3'b001, 5'd11, 5'd12, 13'd24);
    branchCase(3'b100, 5'd10, 5'd11, 13'h1ff0);
    branchCase(3'b100, 5'd11, 5'd10, 13'd24);
    branchCase(3'b101, 5'd11, 5'd10, 13'h1ff0);
    branchCase(3'b101, 5'd10, 5'd11, 13'd24);
    branchCase(3'b110, 5'd11, 5'd10, 13'h1ff0);
    branchCase(3'b110, 5'd10, 5'd11, 13'd24);
    branchCase(3'b111, 5'd10, 5'd11, 13'h1ff0);
    branchCase(3'b111, 5'd11, 5'd10, 13'd24);
    applyInst(jInst(21'd2048, 5'd1), pc, 1'b1, 1'b0);
    checkEq("npcKind", 64'(npcKind), 64'(npcJal));
    checkEq("npcTarget", npcTarget, pc + sext21(21'd2048));
    checkEq("exRd1", exRd1, pc);
    checkEq("exRd2", exRd2, 64'd4);
    applyInst(iInst(12'h007, 5'd13, 3'b000, 5'd1, opJalr), pc, 1'b1, 1'b0);
    checkEq("npcKind", 64'(npcKind), 64'(npcJalr));
    checkEq("npcTarget", npcTarget, (regVal[13] + 64'd7) & ~64'd1);
    applyInst(32'h0000_0073, pc, 1'b1, 1'b0);
    checkEq("npcKind", 64'(npcKind), 64'(npcEcall));
    checkEq("npcTarget", npcTarget, mtvec);
    checkBit("exEcall", exEcall, 1'b1);
    checkBit("exMret", exMret, 1'b0);
    applyInst(32'h3020_0073, pc, 1'b1, 1'b0);
    checkEq("npcKind", 64'(npcKind), 64'(npcMret));
    checkEq("npcTarget", npcTarget, mepc);
    checkBit("exEcall", exEcall, 1'b0);
    checkBit("exMret", exMret, 1'b1);
    applyInst(rInst(7'h00, 5'd12, 5'd11, 3'b000, 5'd3, opR), pc, 1'b1, 1'b0);
    checkEq("npcKind", 64'(npcKind), 64'(npcSeq));
    checkEq("npcTarget", npcTarget, pc + 64'd4);
    checkBit("exEcall", exEcall, 1'b0);
    checkBit("exMret", exMret, 1'b0);
  endtask

  task automatic flagTest();
    logic [Xlen-1:0] pc;
    pc = pcBase + 64'h300;
    writeReg(5'd1, randWord());
    applyInst(iInst(12'd8, 5'd1, 3'b011, 5'd3, opLoad), pc, 1'b1, 1'b0);
    checkFlags(1'b1, 1'b0, 8'h00, 1'b1, 1'b0, 1'b0, 1'b0);
    for (int w = 0; w < 4; w++) begin
      applyInst(sInst(12'd16, 5'd2, 5'd1, 3'(w)), pc, 1'b1, 1'b0);
      checkFlags(1'b0, 1'b1, storeMask(2'(w)), 1'b0, 1'b0, 1'b0, 1'b0);
    end
    applyInst(iInst(12'h300, 5'd1, 3'b001, 5'd3, opSystem), pc, 1'b1, 1'b0);
    checkFlags(1'b0, 1'b0, 8'h00, 1'b1, 1'b1, 1'b0, 1'b0);
    checkEq("exRd1", exRd1, regVal[1]);
    checkEq("exRd2", exRd2, 64'd0);
    applyInst(32'h0010_0073, pc, 1'b1, 1'b1);
    checkFlags(1'b0, 1'b0, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0);
    checkBit("ifReady", ifReady, 1'b0);
    applyInst(32'hffff_ffff, pc, 1'b1, 1'b0);
    checkFlags(1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic hazardTest();
    logic [Xlen-1:0] val;
    val = randWord();
    applyInst(iInst(12'd1, 5'd0, 3'b000, 5'd5, opImm), pcBase, 1'b1, 1'b1);
    checkBit("exValid", exValid, 1'b1);
    // reader of x5 waits for the writeback
    applyInst(rInst(7'h00, 5'd0, 5'd5, 3'b000, 5'd0, opR), pcBase + 64'd4, 1'b1, 1'b1);
    for (int i = 0; i < 3; i++) begin
      checkBit("exValid", exValid, 1'b0);
      checkBit("ifReady", ifReady, 1'b0);
      tick();
      #1;
    end
    tick();
    wbEn = 1'b1;
    wbAddr = 5'd5;
    wbData = val;
    regVal[5] = val;
    #1;
    checkBit("exValid", exValid, 1'b1);
    checkBit("ifReady", ifReady, 1'b1);
    checkEq("exRd1", exRd1, val);
    // x0 is never marked pending
    applyInst(iInst(12'd3, 5'd0, 3'b000, 5'd0, opImm), pcBase + 64'd8, 1'b1, 1'b1);
    checkBit("exValid", exValid, 1'b1);
    applyInst(rInst(7'h00, 5'd0, 5'd0, 3'b000, 5'd0, opR), pcBase + 64'd12, 1'b1, 1'b1);
    checkBit("exValid", exValid, 1'b1);
    checkBit("ifReady", ifReady, 1'b1);
  endtask

  task automatic backPressureTest();
    applyInst(iInst(12'd9, 5'd0, 3'b000, 5'd5, opImm), pcBase, 1'b1, 1'b0);
    checkBit("exValid", exValid, 1'b1);
    checkBit("ifReady", ifReady, 1'b0);
    tick();
    #1;
    checkBit("ifReady", ifReady, 1'b0);
    checkEq("exRd2", exRd2, 64'd9);
    applyInst(rInst(7'h00, 5'd0, 5'd5, 3'b000, 5'd0, opR), pcBase + 64'd4, 1'b1, 1'b1);
    checkBit("exValid", exValid, 1'b1);
    checkBit("ifReady", ifReady, 1'b1);
    checkEq("exRd1", exRd1, regVal[5]);
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    ifValid = 1'b0;
    ifInst = 32'h0000_0013;
    ifPc = pcBase;
    nextPc = pcBase + 64'd4;
    exReady = 1'b0;
    wbEn = 1'b0;
    wbAddr = 5'd0;
    wbData = 64'd0;
    mtvec = 64'h0000_0000_8000_0100;
    mepc = 64'h0000_0000_8000_2344;
    for (int r = 0; r < 32; r++) begin
      regVal[r] = 64'd0;
    end
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    resetTest();
    aluTest();
    branchTest();
    flagTest();
    hazardTest();
    backPressureTest();
    tick();
    ifValid = 1'b0;
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== hw/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       ifValid,
  input  logic [31:0]                ifInst,
  input  logic [decodePkg::Xlen-1:0] ifPc,
  input  logic [decodePkg::Xlen-1:0] nextPc,
  input  logic                       exReady,
  input  logic                       wbEn,
  input  decodePkg::regAddrT         wbAddr,
  input  logic [decodePkg::Xlen-1:0] wbData,
  input  logic [decodePkg::Xlen-1:0] mtvec,
  input  logic [decodePkg::Xlen-1:0] mepc,
  output logic                       exValid,
  output logic [decodePkg::Xlen-1:0] exPc,
  output decodePkg::aluOpE           exOp,
  output logic [decodePkg::Xlen-1:0] exRd1,
  output logic [decodePkg::Xlen-1:0] exRd2,
  output logic [decodePkg::Xlen-1:0] exRs2,
  output logic [decodePkg::Xlen-1:0] exImm,
  output decodePkg::regAddrT         exWaddr,
  output logic                       exWen,
  output logic                       exLoad,
  output logic                       exStore,
  output logic [7:0]                 exWmask,
  output logic                       exWordOp,
  output logic                       exCsr,
  output logic                       exEcall,
  output logic                       exMret,
  output logic                       exBreak,
  output logic                       exAbort,
  output logic [2:0]                 exFunc3,
  output logic                       ifReady,
  output decodePkg::npcKindE         npcKind,
  output logic [decodePkg::Xlen-1:0] npcTarget,
  output logic                       npcValid
);
  import decodePkg::*;

  regAddrT         raddr1;
  regAddrT         raddr2;
  logic [Xlen-1:0] rdata1;
  logic [Xlen-1:0] rdata2;
  logic            pass1;
  logic            pass2;
  logic            busy1;
  logic            busy2;
  logic            issue;
  regAddrT         issueAddr;
  instTypeE        instType;
  logic [Xlen-1:0] rs1Data;
  logic [Xlen-1:0] rs2Data;

  regFile regs0 (
    .clock  (clock),
    .reset  (reset),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .wen    (wbEn),
    .waddr  (wbAddr),
    .wdata  (wbData),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .pass1  (pass1),
    .pass2  (pass2)
  );

  scoreboard score0 (
    .clock     (clock),
    .reset     (reset),
    .issue     (issue),
    .issueAddr (issueAddr),
    .wbEn      (wbEn),
    .wbAddr    (wbAddr),
    .raddr1    (raddr1),
    .raddr2    (raddr2),
    .busy1     (busy1),
    .busy2     (busy2)
  );

  instDecoder dec0 (
    .inst      (ifInst),
    .pc        (ifPc),
    .valid     (ifValid),
    .exReady   (exReady),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .pass1     (pass1),
    .pass2     (pass2),
    .busy1     (busy1),
    .busy2     (busy2),
    .raddr1    (raddr1),
    .raddr2    (raddr2),
    .exValid   (exValid),
    .exPc      (exPc),
    .exOp      (exOp),
    .exRd1     (exRd1),
    .exRd2     (exRd2),
    .exRs2     (exRs2),
    .exImm     (exImm),
    .exWaddr   (exWaddr),
    .exWen     (exWen),
    .exLoad    (exLoad),
    .exStore   (exStore),
    .exWmask   (exWmask),
    .exWordOp  (exWordOp),
    .exCsr     (exCsr),
    .exEcall   (exEcall),
    .exMret    (exMret),
    .exBreak   (exBreak),
    .exAbort   (exAbort),
    .exFunc3   (exFunc3),
    .issue     (issue),
    .issueAddr (issueAddr),
    .ifReady   (ifReady),
    .instType  (instType),
    .rs1Data   (rs1Data),
    .rs2Data   (rs2Data)
  );

  branchResolve npc0 (
    .instType  (instType),
    .inst      (ifInst),
    .pc        (ifPc),
    .imm       (exImm),
    .rs1Data   (rs1Data),
    .rs2Data   (rs2Data),
    .nextPc    (nextPc),
    .mtvec     (mtvec),
    .mepc      (mepc),
    .valid     (exValid),
    .npcKind   (npcKind),
    .npcTarget (npcTarget),
    .npcValid  (npcValid)
  );

endmodule

// ==== hw/branchResolve.sv ====
`timescale 1ns/1ps

module branchResolve (
  input  decodePkg::instTypeE        instType,
  input  logic [31:0]                inst,
  input  logic [decodePkg::Xlen-1:0] pc,
  input  logic [decodePkg::Xlen-1:0] imm,
  input  logic [decodePkg::Xlen-1:0] rs1Data,
  input  logic [decodePkg::Xlen-1:0] rs2Data,
  input  logic [decodePkg::Xlen-1:0] nextPc,
  input  logic [decodePkg::Xlen-1:0] mtvec,
  input  logic [decodePkg::Xlen-1:0] mepc,
  input  logic                       valid,
  output decodePkg::npcKindE         npcKind,
  output logic [decodePkg::Xlen-1:0] npcTarget,
  output logic                       npcValid
);
  import decodePkg::*;

  logic [2:0]      func3;
  logic            eq;
  logic            ltSigned;
  logic            ltUnsigned;
  logic            cond;
  logic            taken;
  logic [Xlen-1:0] jalrSum;

  assign func3      = inst[14:12];
  assign eq         = rs1Data == rs2Data;
  assign ltSigned   = $signed(rs1Data) < $signed(rs2Data);
  assign ltUnsigned = rs1Data < rs2Data;

  always_comb begin
    case (func3)
      3'b000:  cond = eq;
      3'b001:  cond = !eq;
      3'b100:  cond = ltSigned;
      3'b101:  cond = !ltSigned;
      3'b110:  cond = ltUnsigned;
      3'b111:  cond = !ltUnsigned;
      default: cond = 1'b0;
    endcase
  end

  assign taken = instType == typeB && cond;

  // first match wins
  always_comb begin
    if (inst[6:0] == opJalr) begin
      npcKind = npcJalr;
    end else if (inst == 32'h0000_0073) begin
      npcKind = npcEcall;
    end else if (taken) begin
      npcKind = npcBranch;
    end else if (inst == 32'h3020_0073) begin
      npcKind = npcMret;
    end else if (instType == typeJ) begin
      npcKind = npcJal;
    end else begin
      npcKind = npcSeq;
    end
  end

  assign jalrSum = rs1Data + imm;

  always_comb begin
    case (npcKind)
      npcJalr:           npcTarget = {jalrSum[Xlen-1:1], 1'b0};
      npcBranch, npcJal: npcTarget = pc + imm;
      npcEcall:          npcTarget = mtvec;
      npcMret:           npcTarget = mepc;
      default:           npcTarget = nextPc;
    endcase
  end

  assign npcValid = valid;

endmodule

// ==== hw/instDecoder.sv ====
`timescale 1ns/1ps

module instDecoder (
  input  logic [31:0]                inst,
  input  logic [decodePkg::Xlen-1:0] pc,
  input  logic                       valid,
  input  logic                       exReady,
  input  logic [decodePkg::Xlen-1:0] rdata1,
  input  logic [decodePkg::Xlen-1:0] rdata2,
  input  logic                       pass1,
  input  logic                       pass2,
  input  logic                       busy1,
  input  logic                       busy2,
  output decodePkg::regAddrT         raddr1,
  output decodePkg::regAddrT         raddr2,
  output logic                       exValid,
  output logic [decodePkg::Xlen-1:0] exPc,
  output decodePkg::aluOpE           exOp,
  output logic [decodePkg::Xlen-1:0] exRd1,
  output logic [decodePkg::Xlen-1:0] exRd2,
  output logic [decodePkg::Xlen-1:0] exRs2,
  output logic [decodePkg::Xlen-1:0] exImm,
  output decodePkg::regAddrT         exWaddr,
  output logic                       exWen,
  output logic                       exLoad,
  output logic                       exStore,
  output logic [7:0]                 exWmask,
  output logic                       exWordOp,
  output logic                       exCsr,
  output logic                       exEcall,
  output logic                       exMret,
  output logic                       exBreak,
  output logic                       exAbort,
  output logic [2:0]                 exFunc3,
  output logic                       issue,
  output decodePkg::regAddrT         issueAddr,
  output logic                       ifReady,
  output decodePkg::instTypeE        instType,
  output logic [decodePkg::Xlen-1:0] rs1Data,
  output logic [decodePkg::Xlen-1:0] rs2Data
);
  import decodePkg::*;

  opcodeE          opcode;
  logic [2:0]      func3;
  logic [6:0]      func7;
  logic            altFlag;
  logic [5:0]      shamt;
  logic [Xlen-1:0] immI;
  logic [Xlen-1:0] immS;
  logic [Xlen-1:0] immB;
  logic [Xlen-1:0] immU;
  logic [Xlen-1:0] immJ;
  logic [Xlen-1:0] imm;
  logic [Xlen-1:0] rs1Sext;
  logic [Xlen-1:0] rs1Zext;
  logic [Xlen-1:0] rs2Sext;
  logic            isRType;
  logic            isArith;
  logic            isJalr;
  logic            isEbreak;
  logic            wordShiftR;
  logic            wordMulDiv;
  logic            rs2Low5;
  logic            srl64;
  logic            shamtSel;
  logic            stall;

  assign opcode  = opcodeE'(inst[6:0]);
  assign func3   = inst[14:12];
  assign func7   = inst[31:25];
  // bit 30 picks sub and the arithmetic shifts
  assign altFlag = inst[30];
  assign shamt   = inst[25:20];

  always_comb begin
    case (opcode)
      opR, opRw:                               instType = typeR;
      opImm, opImmW, opLoad, opJalr, opSystem: instType = typeI;
      opStore:                                 instType = typeS;
      opBranch:                                instType = typeB;
      opAuipc, opLui:                          instType = typeU;
      opJal:                                   instType = typeJ;
      default:                                 instType = typeBad;
    endcase
  end

  assign immI = {{(Xlen-12){inst[31]}}, inst[31:20]};
  assign immS = {{(Xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{(Xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {{(Xlen-32){inst[31]}}, inst[31:12], 12'h000};
  assign immJ = {{(Xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (instType)
      typeI:   imm = immI;
      typeS:   imm = immS;
      typeB:   imm = immB;
      typeU:   imm = immU;
      typeJ:   imm = immJ;
      default: imm = '0;
    endcase
  end

  assign isRType  = instType == typeR;
  assign isArith  = isRType || opcode == opImm || opcode == opImmW;
  assign isJalr   = opcode == opJalr;
  assign isEbreak = inst == 32'h0010_0073;

  // srlw, sraw, srliw and sraiw narrow rs1 before the shift
  assign wordShiftR = exWordOp && func3 == 3'b101 && !func7[0];
  // divw, divuw, remw, remuw
  assign wordMulDiv = opcode == opRw && func7[0] && func3[2];
  assign rs2Low5    = opcode == opRw && !func7[0] && (func3 == 3'b001 || func3 == 3'b101);
  assign srl64      = opcode == opR && func7 == 7'b0000000 && func3 == 3'b101;
  assign shamtSel   = (opcode == opImm || opcode == opImmW) && func3[1:0] == 2'b01;

  assign rs1Sext = {{(Xlen-32){rdata1[31]}}, rdata1[31:0]};
  assign rs1Zext = {{(Xlen-32){1'b0}}, rdata1[31:0]};
  assign rs2Sext = {{(Xlen-32){rdata2[31]}}, rdata2[31:0]};

  always_comb begin
    exOp = aluAdd;
    if (isRType && func7[0]) begin
      // M extension, unsigned forms are the plain names
      case (func3)
        3'b100:  exOp = aluDivs;
        3'b101:  exOp = aluDiv;
        3'b110:  exOp = aluRems;
        3'b111:  exOp = aluRem;
        default: exOp = aluMul;
      endcase
    end else if (isArith) begin
      case (func3)
        3'b000:  exOp = (isRType && altFlag) ? aluSub : aluAdd;
        3'b001:  exOp = exWordOp ? aluSllw : aluSll;
        3'b010:  exOp = aluSlt;
        3'b011:  exOp = aluSltu;
        3'b100:  exOp = aluXor;
        3'b101:  exOp = altFlag ? aluSra : aluSrl;
        3'b110:  exOp = aluOr;
        default: exOp = aluAnd;
      endcase
    end
  end

  always_comb begin
    case (instType)
      typeR: begin
        if (wordMulDiv) begin
          exRd1 = rs1Sext;
          exRd2 = rs2Sext;
        end else begin
          exRd1 = wordShiftR ? (altFlag ? rs1Sext : rs1Zext) : rdata1;
          exRd2 = rs2Low5 ? Xlen'(rdata2[4:0]) : srl64 ? Xlen'(rdata2[5:0]) : rdata2;
        end
      end
      typeI: begin
        exRd1 = isJalr ? pc : wordShiftR ? (altFlag ? rs1Sext : rs1Zext) : rdata1;
        exRd2 = exCsr ? '0 : isJalr ? Xlen'(4) : shamtSel ? Xlen'(shamt) : imm;
      end
      typeS: begin
        exRd1 = rdata1;
        exRd2 = imm;
      end
      typeU: begin
        exRd1 = (opcode == opAuipc) ? pc : '0;
        exRd2 = imm;
      end
      typeJ: begin
        exRd1 = pc;
        exRd2 = Xlen'(4);
      end
      default: begin
        exRd1 = '0;
        exRd2 = '0;
      end
    endcase
  end

  // byte enables per store width
  always_comb begin
    case (func3)
      3'b000:  exWmask = 8'h01;
      3'b001:  exWmask = 8'h03;
      3'b010:  exWmask = 8'h0F;
      3'b011:  exWmask = 8'hFF;
      default: exWmask = 8'h00;
    endcase
    if (!exStore) begin
      exWmask = 8'h00;
    end
  end

  assign exLoad   = opcode == opLoad;
  assign exStore  = opcode == opStore;
  assign exWordOp = opcode == opRw || opcode == opImmW;
  assign exCsr    = opcode == opSystem && func3 != 3'b000;
  assign exEcall  = inst == 32'h0000_0073;
  assign exMret   = inst == 32'h3020_0073;
  assign exBreak  = isEbreak;
  assign exAbort  = instType == typeBad;
  assign exWen    = !(instType inside {typeS, typeB, typeBad});
  assign exFunc3  = func3;
  assign exPc     = pc;
  assign exImm    = imm;
  assign exRs2    = rdata2;
  assign exWaddr  = inst[11:7];

  assign raddr1  = inst[19:15];
  assign raddr2  = inst[24:20];
  assign rs1Data = rdata1;
  assign rs2Data = rdata2;

  // busy source with no writeback this cycle holds the instruction
  assign stall   = (busy1 && !pass1) || (busy2 && !pass2);
  assign exValid = valid && !stall;
  assign ifReady = exReady && !stall && !isEbreak;

  assign issue     = exValid && exReady && exWen;
  assign issueAddr = inst[11:7];

endmodule

// ==== hw/scoreboard.sv ====
`timescale 1ns/1ps

module scoreboard (
  input  logic               clock,
  input  logic               reset,
  input  logic               issue,
  input  decodePkg::regAddrT issueAddr,
  input  logic               wbEn,
  input  decodePkg::regAddrT wbAddr,
  input  decodePkg::regAddrT raddr1,
  input  decodePkg::regAddrT raddr2,
  output logic               busy1,
  output logic               busy2
);
  import decodePkg::*;

  // one pending-write bit per architectural register
  logic [31:0] busy;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (wbEn) begin
        busy[wbAddr] <= 1'b0;
      end
      // issue comes last so a same-edge set beats the clear
      if (issue && issueAddr != '0) begin
        busy[issueAddr] <= 1'b1;
      end
    end
  end

  assign busy1 = busy[raddr1];
  assign busy2 = busy[raddr2];

  // a bit only rises after an issue that targets it
  for (genvar i = 0; i < 32; i++) begin : gSetCheck
    assert property (@(posedge clock) disable iff (reset)
      $rose(busy[i]) |-> $past(issue) && $past(issueAddr) == regAddrT'(i));
  end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic                        clock,
  input  logic                        reset,
  input  decodePkg::regAddrT          raddr1,
  input  decodePkg::regAddrT          raddr2,
  input  logic                        wen,
  input  decodePkg::regAddrT          waddr,
  input  logic [decodePkg::Xlen-1:0]  wdata,
  output logic [decodePkg::Xlen-1:0]  rdata1,
  output logic [decodePkg::Xlen-1:0]  rdata2,
  output logic                        pass1,
  output logic                        pass2
);
  import decodePkg::*;

  logic [Xlen-1:0] regs [32];

  // writes to x0 are dropped here
  always_ff @(posedge clock) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // writeback in flight is visible in the same cycle
  assign pass1 = wen && waddr == raddr1 && raddr1 != '0;
  assign pass2 = wen && waddr == raddr2 && raddr2 != '0;

  assign rdata1 = pass1 ? wdata : (raddr1 == '0 ? '0 : regs[raddr1]);
  assign rdata2 = pass2 ? wdata : (raddr2 == '0 ? '0 : regs[raddr2]);

endmodule

// ==== hw/decodePkg.sv ====
package decodePkg;

  // register and datapath width of RV64
  localparam int Xlen = 64;

  typedef logic [4:0] regAddrT;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    opR      = 7'b0110011,
    opRw     = 7'b0111011,
    opImm    = 7'b0010011,
    opImmW   = 7'b0011011,
    opLoad   = 7'b0000011,
    opJalr   = 7'b1100111,
    opSystem = 7'b1110011,
    opStore  = 7'b0100011,
    opAuipc  = 7'b0010111,
    opLui    = 7'b0110111,
    opJal    = 7'b1101111,
    opBranch = 7'b1100011
  } opcodeE;

  // format classes, used to pick the immediate
  typedef enum logic [2:0] {
    typeR   = 3'd0,
    typeI   = 3'd1,
    typeS   = 3'd2,
    typeB   = 3'd3,
    typeU   = 3'd4,
    typeJ   = 3'd5,
    typeBad = 3'd6
  } instTypeE;

  // operations understood by execute
  typedef enum logic [4:0] {
    aluAdd  = 5'd0,
    aluSub  = 5'd1,
    aluSll  = 5'd2,
    aluSllw = 5'd3,
    aluSlt  = 5'd4,
    aluSltu = 5'd5,
    aluXor  = 5'd6,
    aluSrl  = 5'd7,
    aluSra  = 5'd8,
    aluOr   = 5'd9,
    aluAnd  = 5'd10,
    aluMul  = 5'd11,
    aluDiv  = 5'd12,
    aluDivs = 5'd13,
    aluRem  = 5'd14,
    aluRems = 5'd15
  } aluOpE;

  // next-pc source for fetch
  typedef enum logic [2:0] {
    npcSeq    = 3'd0,
    npcJal    = 3'd1,
    npcJalr   = 3'd2,
    npcBranch = 3'd3,
    npcEcall  = 3'd4,
    npcMret   = 3'd5
  } npcKindE;

endpackage
